/* hw/booth_mul_pkg.sv */
//*********************************************************************
// shared widths and payload structs of the 32-bit Booth multiplier
// compressor widths below assume REG_WIDTH = 32 and 16 Booth digits
//*********************************************************************

package booth_mul_pkg;

	localparam int REG_WIDTH    = 32;
	localparam int PROD_WIDTH   = 2 * REG_WIDTH;
	localparam int DIGIT_COUNT  = REG_WIDTH / 2;
	localparam int PP_ROW_WIDTH = REG_WIDTH + 4;  // middle row with its 1 ~S prefix
	localparam int PIPE_DEPTH   = 3;

	// compressor row widths per tree level
	localparam int L1_EDGE_WIDTH = REG_WIDTH + 10;
	localparam int L1_MID_WIDTH  = REG_WIDTH + 12;
	localparam int L2_LOW_WIDTH  = REG_WIDTH + 19;
	localparam int L2_HIGH_WIDTH = REG_WIDTH + 18;
	localparam int CLA_GROUPS    = PROD_WIDTH / 4;

	typedef logic [PROD_WIDTH-1:0] product_t;

	typedef struct packed {
		logic [REG_WIDTH-1:0] a;
		logic [REG_WIDTH-1:0] b;
		logic                 a_unsigned;  // set means zero-extend
		logic                 b_unsigned;
	} mul_operands_t;

	typedef struct packed {
		logic zero;
		logic invert;
		logic twice;
	} booth_digit_t;

	typedef booth_digit_t [DIGIT_COUNT-1:0] booth_digits_t;

	typedef struct packed {
		logic [PP_ROW_WIDTH:0]                    first;     // ~S S S prefix
		logic [DIGIT_COUNT-3:0][PP_ROW_WIDTH-1:0] mid;
		logic [REG_WIDTH+1:0]                     last;      // sign bits fall off the top
		logic [DIGIT_COUNT-1:0][1:0]              plus_one;  // +1 of each negated row
		product_t                                 correction_row;
	} pp_set_t;

	typedef struct packed {
		product_t sum;
		product_t carry;  // not yet shifted
	} csa_pair_t;

endpackage

/* hw/booth_encoder.sv */
//*********************************************************************
// radix-4 Booth encoding of B, purely combinational
// an unsigned B with its top bit set needs a 17th digit, folded into
// the correction row as A at bit REG_WIDTH
//*********************************************************************

`timescale 1ns/1ps

module booth_encoder (
	input  logic [booth_mul_pkg::REG_WIDTH-1:0] b,
	input  logic                                b_unsigned,
	input  logic [booth_mul_pkg::REG_WIDTH-1:0] a,
	output booth_mul_pkg::booth_digits_t        digits,
	output booth_mul_pkg::product_t             correction_row
);

	logic [booth_mul_pkg::REG_WIDTH:0] b_pad;  // implicit b[-1] = 0
	logic                              top_digit;
	logic [1:0]                        top_plus;

	assign b_pad = {b, 1'b0};

	always_comb begin
		logic [2:0] win;
		for (int i = 0; i < booth_mul_pkg::DIGIT_COUNT; i++) begin
			win = b_pad[2*i +: 3];
			digits[i].zero   = (win == 3'b000) || (win == 3'b111);
			digits[i].invert = win[2] & ~(win[1] & win[0]);  // 111 is +0, not -0
			digits[i].twice  = (win == 3'b011) || (win == 3'b100);
		end
	end

	// window {0,0,b[31]} of the zero-extended B
	assign top_digit = b_unsigned & b[booth_mul_pkg::REG_WIDTH-1];

	// +1 of the last row has no row below it
	assign top_plus = {digits[booth_mul_pkg::DIGIT_COUNT-1].invert &
	                   digits[booth_mul_pkg::DIGIT_COUNT-1].twice,
	                   digits[booth_mul_pkg::DIGIT_COUNT-1].invert &
	                   ~digits[booth_mul_pkg::DIGIT_COUNT-1].twice};

	assign correction_row = {top_digit ? a : {booth_mul_pkg::REG_WIDTH{1'b0}},
	                         top_plus,
	                         {(booth_mul_pkg::REG_WIDTH-2){1'b0}}};

endmodule

/* hw/partial_product_gen.sv */
//*********************************************************************
// Booth partial-product rows of A, combinational
// the +1 of a negated row is emitted separately, to be placed under
// the next row; the correction row is left zero for the top level
//*********************************************************************

`timescale 1ns/1ps

module partial_product_gen (
	input  logic [booth_mul_pkg::REG_WIDTH-1:0] a,
	input  logic                                a_unsigned,
	input  booth_mul_pkg::booth_digits_t        digits,
	output booth_mul_pkg::pp_set_t              pp
);

	logic [booth_mul_pkg::REG_WIDTH:0] a_ext;

	// one extra bit so both signed and unsigned A are 33-bit signed
	assign a_ext = {a_unsigned ? 1'b0 : a[booth_mul_pkg::REG_WIDTH-1], a};

	for (genvar i = 0; i < booth_mul_pkg::DIGIT_COUNT; i++) begin : g_digit
		logic [booth_mul_pkg::REG_WIDTH:0]   a_sel;
		logic [booth_mul_pkg::REG_WIDTH+1:0] field;  // 34-bit signed multiple
		logic                                sgn;

		assign a_sel = digits[i].invert ? ~a_ext : a_ext;

		always_comb begin
			if (digits[i].zero) begin
				field = '0;
			end else if (digits[i].twice) begin
				field = {a_sel, 1'b0};
			end else begin
				field = {a_sel[booth_mul_pkg::REG_WIDTH], a_sel};  // sign extend by one
			end
		end

		assign sgn = a_sel[booth_mul_pkg::REG_WIDTH] & ~digits[i].zero;

		// bit 0 for -A, bit 1 for -2A
		assign pp.plus_one[i] = {digits[i].invert & digits[i].twice,
		                         digits[i].invert & ~digits[i].twice};

		if (i == 0) begin : g_first
			assign pp.first = {~sgn, sgn, sgn, field};
		end else if (i == booth_mul_pkg::DIGIT_COUNT - 1) begin : g_last
			assign pp.last = field;  // prefix would land above bit 63
		end else begin : g_mid
			assign pp.mid[i-1] = {1'b1, ~sgn, field};
		end
	end

	assign pp.correction_row = '0;  // comes from the encoder

endmodule

/* hw/compressor_42.sv */
//*********************************************************************
// row of 4-2 compressor cells
// sum + (carry << 1) + (carry_top << WIDTH) equals in0+in1+in2+in3
//*********************************************************************

`timescale 1ns/1ps

module compressor_42 #(
	parameter int WIDTH = 8
) (
	input  logic [WIDTH-1:0] in0,
	input  logic [WIDTH-1:0] in1,
	input  logic [WIDTH-1:0] in2,
	input  logic [WIDTH-1:0] in3,
	output logic [WIDTH-1:0] sum,
	output logic [WIDTH-1:0] carry,
	output logic             carry_top
);

	logic [WIDTH-1:0] xor3;
	logic [WIDTH:0]   chain;  // chain[j] is the intermediate carry into cell j

	assign xor3 = in0 ^ in1 ^ in2;

	// intermediate carry depends only on the first three inputs, so no ripple
	assign chain = {(in0 & in1) | (in0 & in2) | (in1 & in2), 1'b0};

	assign sum   = xor3 ^ in3 ^ chain[WIDTH-1:0];
	assign carry = (xor3 & in3) | (xor3 & chain[WIDTH-1:0]) | (in3 & chain[WIDTH-1:0]);

	assign carry_top = chain[WIDTH];

endmodule

/* hw/wallace_tree.sv */
//*********************************************************************
// three-level 4-2 reduction of the 16 Booth rows to a sum/carry pair
// row offsets are laid out for a 32-bit operand; anything at or above
// bit 64 is dropped, since only the low product half is kept
//*********************************************************************

`timescale 1ns/1ps

module wallace_tree (
	input  booth_mul_pkg::pp_set_t   pp,
	output booth_mul_pkg::csa_pair_t tree
);

	logic [booth_mul_pkg::L1_EDGE_WIDTH-1:0]     l1_lo_s, l1_lo_c;
	logic                                        l1_lo_top;
	logic [1:0][booth_mul_pkg::L1_MID_WIDTH-1:0] l1_mid_s, l1_mid_c;
	logic [1:0]                                  l1_mid_top;
	logic [booth_mul_pkg::L1_EDGE_WIDTH-1:0]     l1_hi_s, l1_hi_c;
	logic [booth_mul_pkg::L2_LOW_WIDTH-1:0]      l2_lo_s, l2_lo_c;
	logic                                        l2_lo_top;
	logic [booth_mul_pkg::L2_HIGH_WIDTH-1:0]     l2_hi_s, l2_hi_c;

	// level 1, rows 0..3 at bit 0
	compressor_42 #(.WIDTH(booth_mul_pkg::L1_EDGE_WIDTH)) u_l1_lo (
		.in0       ({5'b0, pp.first}),
		.in1       ({4'b0, pp.mid[0], pp.plus_one[0]}),
		.in2       ({2'b0, pp.mid[1], pp.plus_one[1], 2'b0}),
		.in3       ({pp.mid[2], pp.plus_one[2], 4'b0}),
		.sum       (l1_lo_s),
		.carry     (l1_lo_c),
		.carry_top (l1_lo_top)
	);

	// rows 4..7 at bit 6, rows 8..11 at bit 14; +1 bits of the row above sit lowest
	for (genvar k = 0; k < 2; k++) begin : g_l1_mid
		compressor_42 #(.WIDTH(booth_mul_pkg::L1_MID_WIDTH)) u_l1_mid (
			.in0       ({6'b0, pp.mid[4*k+3], pp.plus_one[4*k+3]}),
			.in1       ({4'b0, pp.mid[4*k+4], pp.plus_one[4*k+4], 2'b0}),
			.in2       ({2'b0, pp.mid[4*k+5], pp.plus_one[4*k+5], 4'b0}),
			.in3       ({pp.mid[4*k+6], pp.plus_one[4*k+6], 6'b0}),
			.sum       (l1_mid_s[k]),
			.carry     (l1_mid_c[k]),
			.carry_top (l1_mid_top[k])
		);
	end

	// rows 12..15 at bit 22, reaches bit 63 exactly
	compressor_42 #(.WIDTH(booth_mul_pkg::L1_EDGE_WIDTH)) u_l1_hi (
		.in0       ({4'b0, pp.mid[11], pp.plus_one[11]}),
		.in1       ({2'b0, pp.mid[12], pp.plus_one[12], 2'b0}),
		.in2       ({pp.mid[13], pp.plus_one[13], 4'b0}),
		.in3       ({pp.last, pp.plus_one[14], 6'b0}),
		.sum       (l1_hi_s),
		.carry     (l1_hi_c),
		.carry_top ()
	);

	// level 2, groups 0/1 at bit 0
	compressor_42 #(.WIDTH(booth_mul_pkg::L2_LOW_WIDTH)) u_l2_lo (
		.in0       ({8'b0, l1_lo_top, l1_lo_s}),
		.in1       ({8'b0, l1_lo_c, 1'b0}),
		.in2       ({l1_mid_top[0], l1_mid_s[0], 6'b0}),
		.in3       ({l1_mid_c[0], 7'b0}),
		.sum       (l2_lo_s),
		.carry     (l2_lo_c),
		.carry_top (l2_lo_top)
	);

	// groups 2/3 at bit 14
	compressor_42 #(.WIDTH(booth_mul_pkg::L2_HIGH_WIDTH)) u_l2_hi (
		.in0       ({5'b0, l1_mid_top[1], l1_mid_s[1]}),
		.in1       ({5'b0, l1_mid_c[1], 1'b0}),
		.in2       ({l1_hi_s, 8'b0}),
		.in3       ({l1_hi_c[booth_mul_pkg::L1_EDGE_WIDTH-2:0], 9'b0}),  // top carry past bit 63
		.sum       (l2_hi_s),
		.carry     (l2_hi_c),
		.carry_top ()
	);

	// level 3, full product width
	compressor_42 #(.WIDTH(booth_mul_pkg::PROD_WIDTH)) u_l3 (
		.in0       ({12'b0, l2_lo_top, l2_lo_s}),
		.in1       ({12'b0, l2_lo_c, 1'b0}),
		.in2       ({l2_hi_s, 14'b0}),
		.in3       ({l2_hi_c[booth_mul_pkg::L2_HIGH_WIDTH-2:0], 15'b0}),
		.sum       (tree.sum),
		.carry     (tree.carry),
		.carry_top ()
	);

endmodule

/* hw/final_adder.sv */
//*********************************************************************
// 3-2 row on tree sum, tree carry and correction row, then a 64-bit
// carry-lookahead add; result is modulo 2^64
//*********************************************************************

`timescale 1ns/1ps

module final_adder (
	input  booth_mul_pkg::csa_pair_t tree,
	input  booth_mul_pkg::product_t  correction_row,
	output booth_mul_pkg::product_t  product
);

	logic [booth_mul_pkg::PROD_WIDTH-1:0] carry_in_row;
	logic [booth_mul_pkg::PROD_WIDTH-1:0] row_sum, row_carry, add_b;
	logic [booth_mul_pkg::PROD_WIDTH-1:0] prop, gen, carry;
	logic [booth_mul_pkg::CLA_GROUPS-1:0] group_cin;

	assign carry_in_row = {tree.carry[booth_mul_pkg::PROD_WIDTH-2:0], 1'b0};

	// 3-2 row
	assign row_sum   = tree.sum ^ carry_in_row ^ correction_row;
	assign row_carry = (tree.sum & carry_in_row) | (tree.sum & correction_row) |
	                   (carry_in_row & correction_row);
	assign add_b     = {row_carry[booth_mul_pkg::PROD_WIDTH-2:0], 1'b0};

	assign prop = row_sum ^ add_b;
	assign gen  = row_sum & add_b;

	assign group_cin[0] = 1'b0;

	for (genvar g = 0; g < booth_mul_pkg::CLA_GROUPS; g++) begin : g_cla
		logic [3:0] p, k;
		assign p = prop[4*g +: 4];
		assign k = gen[4*g +: 4];

		// lookahead inside the 4-bit group
		assign carry[4*g]   = group_cin[g];
		assign carry[4*g+1] = k[0] | (p[0] & group_cin[g]);
		assign carry[4*g+2] = k[1] | (p[1] & k[0]) | (p[1] & p[0] & group_cin[g]);
		assign carry[4*g+3] = k[2] | (p[2] & k[1]) | (p[2] & p[1] & k[0]) |
		                      (p[2] & p[1] & p[0] & group_cin[g]);

		if (g < booth_mul_pkg::CLA_GROUPS - 1) begin : g_next
			logic grp_gen, grp_prop;
			assign grp_gen  = k[3] | (p[3] & k[2]) | (p[3] & p[2] & k[1]) |
			                  (p[3] & p[2] & p[1] & k[0]);
			assign grp_prop = &p;
			assign group_cin[g+1] = grp_gen | (grp_prop & group_cin[g]);
		end
	end

	assign product = prop ^ carry;

endmodule

/* hw/booth_mul.sv */
//*********************************************************************
// pipelined 32x32 Booth multiplier, low 64 bits of the product
// in_valid at edge N gives out_valid and product at edge N+3
// no back-pressure; a result nobody takes is lost
//*********************************************************************

`timescale 1ns/1ps

module booth_mul (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          in_valid,
	input  booth_mul_pkg::mul_operands_t  operands,
	output logic                          out_valid,
	output booth_mul_pkg::product_t       product
);

	booth_mul_pkg::mul_operands_t         op_q;
	booth_mul_pkg::booth_digits_t         digits;
	booth_mul_pkg::product_t              correction_row;
	booth_mul_pkg::pp_set_t               pp_rows, pp_d, pp_q;
	booth_mul_pkg::csa_pair_t             tree_d, tree_q;
	booth_mul_pkg::product_t              corr_q;
	booth_mul_pkg::product_t              product_d;
	logic [booth_mul_pkg::PIPE_DEPTH-1:0] valid_sr;  // op, pp and tree stages

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_sr  <= '0;
			out_valid <= 1'b0;
		end else begin
			valid_sr  <= {valid_sr[booth_mul_pkg::PIPE_DEPTH-2:0], in_valid};
			out_valid <= valid_sr[booth_mul_pkg::PIPE_DEPTH-1];
		end
	end

	// stage 1 encode + rows
	booth_encoder u_booth_encoder (
		.b              (op_q.b),
		.b_unsigned     (op_q.b_unsigned),
		.a              (op_q.a),
		.digits         (digits),
		.correction_row (correction_row)
	);

	partial_product_gen u_partial_product_gen (
		.a          (op_q.a),
		.a_unsigned (op_q.a_unsigned),
		.digits     (digits),
		.pp         (pp_rows)
	);

	always_comb begin
		pp_d = pp_rows;
		pp_d.correction_row = correction_row;
	end

	// stage 2 reduction, stage 3 final add
	wallace_tree u_wallace_tree (
		.pp   (pp_q),
		.tree (tree_d)
	);

	final_adder u_final_adder (
		.tree           (tree_q),
		.correction_row (corr_q),
		.product        (product_d)
	);

	always_ff @(posedge clk) begin
		if (in_valid) begin
			op_q <= operands;
		end
		pp_q    <= pp_d;
		tree_q  <= tree_d;
		corr_q  <= pp_q.correction_row;  // travels beside the tree pair
		product <= product_d;
	end

endmodule

/* verif/booth_mul_tb.sv */
//*********************************************************************
// directed tests for booth_mul; expected products come from a 64-bit
// multiply of the extended operands, checked at the falling edge
// results must arrive exactly PIPE_DEPTH+1 edges after the drive edge
//*********************************************************************

`timescale 1ns/1ps

module booth_mul_tb;

	localparam int SIGNED_N       = 5;
	localparam int UNSIGNED_N     = 3;
	localparam int MIXED_PAIRS    = 6;
	localparam int STREAM_N       = 400;
	localparam int SPARSE_N       = 50;
	localparam int SPARSE_GAP_MAX = 7;
	localparam int RESET_N        = 4;
	localparam int DRAIN_CYCLES   = booth_mul_pkg::PIPE_DEPTH + 1;
	localparam int MARGIN         = 100;
	localparam int TEST_CYCLES    = SIGNED_N + UNSIGNED_N + 4 * MIXED_PAIRS + STREAM_N +
	                                SPARSE_N * (SPARSE_GAP_MAX + 1) + RESET_N + 10 +
	                                6 * DRAIN_CYCLES;
	localparam int WATCHDOG_NS    = (TEST_CYCLES + booth_mul_pkg::PIPE_DEPTH + MARGIN) * 10 * 2;

	logic                         clk;
	logic                         rst;
	logic                         in_valid;
	booth_mul_pkg::mul_operands_t operands;
	logic                         out_valid;
	booth_mul_pkg::product_t      product;

	int          edge_count = 0;
	logic [31:0] rng_state  = 32'd18793;
	string       current_test = "reset";
	int          value_errors  = 0;
	int          timing_errors = 0;
	int          checked       = 0;

	// pending results, oldest first
	booth_mul_pkg::product_t exp_q[$];
	int                      due_q[$];
	string                   name_q[$];

	booth_mul u_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.operands  (operands),
		.out_valid (out_valid),
		.product   (product)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		edge_count <= edge_count + 1;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic booth_mul_pkg::mul_operands_t make_op(
		input logic [booth_mul_pkg::REG_WIDTH-1:0] a,
		input logic [booth_mul_pkg::REG_WIDTH-1:0] b,
		input logic                                a_unsigned,
		input logic                                b_unsigned
	);
		booth_mul_pkg::mul_operands_t op;
		op.a          = a;
		op.b          = b;
		op.a_unsigned = a_unsigned;
		op.b_unsigned = b_unsigned;
		return op;
	endfunction

	function automatic booth_mul_pkg::mul_operands_t random_op();
		logic [31:0] flags;
		flags = next_random();
		return make_op(next_random(), next_random(), flags[7], flags[3]);
	endfunction

	// extend each operand by its flag, keep the low 64 bits
	function automatic booth_mul_pkg::product_t ref_product(booth_mul_pkg::mul_operands_t op);
		logic                    a_fill;
		logic                    b_fill;
		booth_mul_pkg::product_t a_ext;
		booth_mul_pkg::product_t b_ext;
		a_fill = op.a_unsigned ? 1'b0 : op.a[booth_mul_pkg::REG_WIDTH-1];
		b_fill = op.b_unsigned ? 1'b0 : op.b[booth_mul_pkg::REG_WIDTH-1];
		a_ext  = {{booth_mul_pkg::REG_WIDTH{a_fill}}, op.a};
		b_ext  = {{booth_mul_pkg::REG_WIDTH{b_fill}}, op.b};
		return a_ext * b_ext;
	endfunction

	task automatic check_product(
		input string                   test_name,
		input booth_mul_pkg::product_t expected,
		input booth_mul_pkg::product_t actual
	);
		checked++;
		if (actual !== expected) begin
			value_errors++;
			$display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_valid_timing(input logic due, input logic actual_valid);
		if (due && actual_valid !== 1'b1) begin
			timing_errors++;
			$display("%s: out_valid missing at edge %0d where a result was due",
			         current_test, edge_count);
		end else if (!due && actual_valid !== 1'b0) begin
			timing_errors++;
			$display("%s: out_valid high at edge %0d with no result due",
			         current_test, edge_count);
		end
	endtask

	// outputs are stable half a cycle after the edge
	always @(negedge clk) begin : check_outputs
		logic due;
		due = (due_q.size() > 0) && (due_q[0] == edge_count);
		check_valid_timing(due, out_valid);
		if (due) begin
			if (out_valid === 1'b1) begin
				check_product(name_q[0], exp_q[0], product);
			end
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
			void'(name_q.pop_front());
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_strobe(input booth_mul_pkg::mul_operands_t op);
		in_valid = 1'b1;
		operands = op;
		exp_q.push_back(ref_product(op));
		due_q.push_back(edge_count + 1 + booth_mul_pkg::PIPE_DEPTH);  // sampled at next edge
		name_q.push_back(current_test);
		step();
	endtask

	task automatic idle(input int cycles);
		in_valid = 1'b0;
		repeat (cycles) step();
	endtask

	task automatic wait_drain();
		in_valid = 1'b0;
		while (due_q.size() > 0) begin
			step();
		end
	endtask

	// results due after the given edge are flushed by reset
	task automatic drop_pending(input int last_edge);
		while (due_q.size() > 0 && due_q[$] > last_edge) begin
			void'(exp_q.pop_back());
			void'(due_q.pop_back());
			void'(name_q.pop_back());
		end
	endtask

	task automatic test_signed_corners();
		current_test = "signed_corners";
		drive_strobe(make_op(32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0));
		drive_strobe(make_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 1'b0));
		drive_strobe(make_op(32'h8000_0000, 32'h7FFF_FFFF, 1'b0, 1'b0));
		drive_strobe(make_op(32'h0000_0000, 32'hDEAD_BEEF, 1'b0, 1'b0));
		drive_strobe(make_op(32'h0000_0001, 32'hFFFF_FFFF, 1'b0, 1'b0));
		wait_drain();
	endtask

	task automatic test_unsigned_corners();
		current_test = "unsigned_corners";
		drive_strobe(make_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1, 1'b1));
		drive_strobe(make_op(32'hFFFF_FFFF, 32'h0000_0002, 1'b1, 1'b1));
		drive_strobe(make_op(32'h8000_0000, 32'h8000_0000, 1'b1, 1'b1));
		wait_drain();
	endtask

	task automatic test_mixed_modes();
		logic [booth_mul_pkg::REG_WIDTH-1:0] pair_a [MIXED_PAIRS];
		logic [booth_mul_pkg::REG_WIDTH-1:0] pair_b [MIXED_PAIRS];
		current_test = "mixed_modes";
		pair_a = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
		           32'h1234_5678, 32'hFFFF_FFFF, 32'h0000_0003};
		pair_b = '{32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFE,
		           32'h9ABC_DEF0, 32'hFFFF_FFFF, 32'h8000_0001};
		for (int mode = 0; mode < 4; mode++) begin
			for (int p = 0; p < MIXED_PAIRS; p++) begin
				drive_strobe(make_op(pair_a[p], pair_b[p], mode[1], mode[0]));
			end
		end
		wait_drain();
	endtask

	task automatic test_stream();
		current_test = "stream";
		for (int i = 0; i < STREAM_N; i++) begin
			drive_strobe(random_op());  // back to back, in_valid never drops
		end
		wait_drain();
	endtask

	task automatic test_sparse();
		int gap;
		current_test = "sparse";
		for (int i = 0; i < SPARSE_N; i++) begin
			drive_strobe(random_op());
			gap = int'(next_random() % (SPARSE_GAP_MAX + 1));
			idle(gap);
		end
		wait_drain();
	endtask

	task automatic test_reset_in_flight();
		current_test = "reset_in_flight";
		repeat (3) drive_strobe(random_op());
		in_valid = 1'b0;
		rst      = 1'b1;
		drop_pending(edge_count);
		step();
		step();
		rst = 1'b0;
		idle(3);  // monitor expects out_valid low here
		drive_strobe(random_op());
		wait_drain();
	endtask

	initial begin
		rst      = 1'b1;
		in_valid = 1'b0;
		operands = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		idle(2);

		test_signed_corners();
		test_unsigned_corners();
		test_mixed_modes();
		test_stream();
		test_sparse();
		test_reset_in_flight();
		idle(2);

		$display("errors: %0d value, %0d timing (%0d products checked)",
		         value_errors, timing_errors, checked);
		if (value_errors + timing_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, current_test);
		$display("Test failures found");
		$finish;
	end

endmodule

/* booth_mul.f */
hw/booth_mul_pkg.sv
hw/booth_encoder.sv
hw/partial_product_gen.sv
hw/compressor_42.sv
hw/wallace_tree.sv
hw/final_adder.sv
hw/booth_mul.sv
verif/booth_mul_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the booth_mul testbench with Verilator
# exit status is non-zero when the build fails or the log reports a failure

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module booth_mul_tb \
	-f booth_mul.f -o booth_mul_sim >build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/booth_mul_sim >sim.log 2>&1 \
	|| { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "Test failures found" sim.log \
	&& { echo "simulation reported failures, see sim.log"; exit 1; } \
	|| { echo "simulation passed, see sim.log"; exit 0; }
